// ==== include/theme_score.svh ====
////////////////////////////////////////
// Looping two-voice phrase
////////////////////////////////////////

localparam int THEME_STEPS = 32;

// Row 0 is the melody, row 1 the bass line.
// Each entry is octave*12 + semitone; 0 leaves the voice silent.
localparam theme_pkg::note_code_t
    THEME_SCORE [theme_pkg::NUM_VOICES][THEME_STEPS] = '{
    '{
        6'd34,                          // Bar 1
        6'd0,
        6'd29,
        6'd30,
        6'd32,                          // Bar 2
        6'd0,
        6'd30,
        6'd29,
        6'd27,                          // Bar 3
        6'd0,
        6'd27,
        6'd30,
        6'd34,                          // Bar 4
        6'd0,
        6'd32,
        6'd30,
        6'd29,                          // Bar 5
        6'd0,
        6'd29,
        6'd30,
        6'd32,                          // Bar 6
        6'd0,
        6'd34,
        6'd0,
        6'd30,                          // Bar 7
        6'd0,
        6'd27,
        6'd0,
        6'd27,                          // Bar 8, tail rests
        6'd0,
        6'd0,
        6'd0
    },
    '{
        6'd10, 6'd22, 6'd10, 6'd22,     // G octave jumps
        6'd10, 6'd22, 6'd10, 6'd22,
        6'd15, 6'd27, 6'd15, 6'd27,     // C
        6'd15, 6'd27, 6'd15, 6'd27,
        6'd14, 6'd26, 6'd14, 6'd26,     // B
        6'd14, 6'd26, 6'd14, 6'd26,
        6'd10, 6'd22, 6'd10, 6'd22,     // Back to G
        6'd8,  6'd20, 6'd8,  6'd20      // F leads into the loop
    }
};

// ==== design/theme_pkg.sv ====
package theme_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int NUM_VOICES = 2;      // Melody and bass
    localparam int STEP_W     = 5;      // 32 steps per phrase
    localparam int CODE_W     = 6;      // Score entry width
    localparam int DIV_W      = 9;      // Note counter width
    localparam int OCT_W      = 8;      // Octave counter width

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    // Score entry, octave*12 + semitone, or 0 for a rest
    typedef logic [CODE_W-1:0] note_code_t;

    typedef struct packed {
        logic [2:0] octave;             // Code divided by twelve
        logic [3:0] semitone;           // Remainder, 0 is A
        logic       rest;               // Code was zero
    } pitch_t;

    typedef struct packed {
        logic             sounding;       // Voice may toggle
        logic [DIV_W-1:0] note_reload;    // Inner prescaler reload
        logic [OCT_W-1:0] octave_reload;  // Outer prescaler reload
    } voice_cmd_t;

    ////////////////////////////////////////
    // Pitch helpers
    ////////////////////////////////////////

    // Clock divider per semitone, A up to G sharp
    function automatic logic [DIV_W-1:0] semitone_divider(input logic [3:0] semitone);
        logic [DIV_W-1:0] div;
        case (semitone)
            4'd0:    div = 9'd511;      // A
            4'd1:    div = 9'd482;      // A sharp
            4'd2:    div = 9'd455;      // B
            4'd3:    div = 9'd430;      // C
            4'd4:    div = 9'd405;      // C sharp
            4'd5:    div = 9'd383;      // D
            4'd6:    div = 9'd361;      // D sharp
            4'd7:    div = 9'd341;      // E
            4'd8:    div = 9'd322;      // F
            4'd9:    div = 9'd303;      // F sharp
            4'd10:   div = 9'd286;      // G
            4'd11:   div = 9'd270;      // G sharp
            default: div = 9'd0;
        endcase
        return div;
    endfunction

    // Only the top four code bits need a real division by three.
    // With code = 4*u + l and u = 3*q + r the semitone is 4*r + l.
    function automatic pitch_t split_code(input note_code_t code);
        pitch_t     p;
        logic [3:0] upper;
        logic [3:0] upper_rem;
        upper       = code[CODE_W-1:2];
        upper_rem   = upper % 4'd3;
        p.octave    = 3'(upper / 4'd3);
        p.semitone  = {upper_rem[1:0], code[1:0]};
        p.rest      = (code == '0);
        return p;
    endfunction

endpackage

// ==== design/score_sequencer.sv ====
module score_sequencer #(
    parameter int STEP_LOG2   = 22,
    parameter int GAP_LOG2    = STEP_LOG2 - 4,
    parameter int PITCH_SHIFT = 0,
    parameter int OCTAVE_TOP  = 255
) (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              run,
    output logic [theme_pkg::STEP_W-1:0]                      step,
    output theme_pkg::voice_cmd_t [theme_pkg::NUM_VOICES-1:0] cmd
);

    `include "theme_score.svh"

    // Top of the octave prescaler before the octave shift
    localparam logic [theme_pkg::OCT_W-1:0] OCT_TOP = OCTAVE_TOP[theme_pkg::OCT_W-1:0];

    ////////////////////////////////////////
    // Tempo and step
    ////////////////////////////////////////

    logic [STEP_LOG2-1:0]         tempo_cnt;       // Clocks into the current step
    logic [STEP_LOG2-1:0]         tempo_next;
    logic                         step_tick;       // Last counted clock of a step
    logic [theme_pkg::STEP_W-1:0] step_next;
    logic                         gap_done;        // Past the silent lead-in

    assign step_tick  = run && (tempo_cnt == '1);
    assign tempo_next = run ? tempo_cnt + 1'b1 : tempo_cnt;   // Wraps on its own

    always_comb begin
        step_next = step;
        if (step_tick) begin
            if (step == theme_pkg::STEP_W'(THEME_STEPS - 1))
                step_next = '0;
            else
                step_next = step + 1'b1;
        end
    end

    // Silent while the counter is still below two to GAP_LOG2
    assign gap_done = (tempo_next[STEP_LOG2-1:GAP_LOG2] != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tempo_cnt <= '0;
            step      <= '0;
        end else begin
            tempo_cnt <= tempo_next;
            step      <= step_next;
        end
    end

    ////////////////////////////////////////
    // Score lookup and voice commands
    ////////////////////////////////////////

    theme_pkg::pitch_t                                 pitch [theme_pkg::NUM_VOICES];
    theme_pkg::voice_cmd_t [theme_pkg::NUM_VOICES-1:0] cmd_next;

    // Commands follow the step that is about to be loaded, so both
    // change on the same edge
    always_comb begin
        for (int v = 0; v < theme_pkg::NUM_VOICES; v++) begin
            pitch[v] = theme_pkg::split_code(THEME_SCORE[v][step_next]);
            cmd_next[v].sounding      = run && !pitch[v].rest && gap_done;
            cmd_next[v].note_reload   =
                theme_pkg::semitone_divider(pitch[v].semitone) >> PITCH_SHIFT;
            cmd_next[v].octave_reload = OCT_TOP >> pitch[v].octave;  // Higher octave, faster
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            cmd <= '0;                  // Every voice silent
        else
            cmd <= cmd_next;
    end

endmodule

// ==== design/tone_voice.sv ====
module tone_voice (
    input  logic                  clk,
    input  logic                  reset,
    input  theme_pkg::voice_cmd_t cmd,
    output logic                  speaker
);

    ////////////////////////////////////////
    // Nested prescalers
    ////////////////////////////////////////

    logic [theme_pkg::DIV_W-1:0] note_cnt;     // Semitone divider
    logic [theme_pkg::OCT_W-1:0] octave_cnt;   // Octave divider
    logic                        note_zero;
    logic                        octave_zero;

    assign note_zero   = (note_cnt == '0);
    assign octave_zero = (octave_cnt == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            note_cnt <= '0;
        end else if (note_zero) begin
            note_cnt <= cmd.note_reload;
        end else begin
            note_cnt <= note_cnt - 1'b1;
        end
    end

    // Outer counter steps once per inner wrap
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            octave_cnt <= '0;
        end else if (note_zero) begin
            if (octave_zero)
                octave_cnt <= cmd.octave_reload;
            else
                octave_cnt <= octave_cnt - 1'b1;
        end
    end

    ////////////////////////////////////////
    // Square wave
    ////////////////////////////////////////

    // Counters keep running while silent, only the toggle is gated
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            speaker <= 1'b0;
        else if (note_zero && octave_zero && cmd.sounding)
            speaker <= ~speaker;        // Half period done
    end

endmodule

// ==== design/theme_player.sv ====
module theme_player #(
    parameter int STEP_LOG2   = 22,
    parameter int GAP_LOG2    = STEP_LOG2 - 4,
    parameter int PITCH_SHIFT = 0,
    parameter int OCTAVE_TOP  = 255
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             run,       // Low pauses the theme
    output logic [theme_pkg::STEP_W-1:0]     step,
    output logic [theme_pkg::NUM_VOICES-1:0] speaker
);

    theme_pkg::voice_cmd_t [theme_pkg::NUM_VOICES-1:0] cmd;   // One per voice

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////

    score_sequencer #(
        .STEP_LOG2   (STEP_LOG2),
        .GAP_LOG2    (GAP_LOG2),
        .PITCH_SHIFT (PITCH_SHIFT),
        .OCTAVE_TOP  (OCTAVE_TOP)
    ) u_score_sequencer (
        .clk   (clk),
        .reset (reset),
        .run   (run),
        .step  (step),
        .cmd   (cmd)
    );

    ////////////////////////////////////////
    // Voices
    ////////////////////////////////////////

    for (genvar v = 0; v < theme_pkg::NUM_VOICES; v++) begin : g_voice
        tone_voice u_tone_voice (
            .clk     (clk),
            .reset   (reset),
            .cmd     (cmd[v]),
            .speaker (speaker[v])     // Straight to the pin
        );
    end

endmodule

// ==== sim/theme_checker.sv ====
module theme_checker #(
    parameter int STEP_LOG2   = 10,
    parameter int GAP_LOG2    = 6,
    parameter int PITCH_SHIFT = 4,
    parameter int OCTAVE_TOP  = 7
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             run,
    input  logic [theme_pkg::STEP_W-1:0]     step,
    input  logic [theme_pkg::NUM_VOICES-1:0] speaker,
    input  logic                             report_req,   // Print the per-test lines
    output bit                               report_done,
    output int                               steps_advanced,
    output int                               check_count,
    output int                               error_count,
    output int                               tests_failed
);

    `include "theme_score.svh"

    localparam int STEP_CLKS  = 1 << STEP_LOG2;
    localparam int GAP_CLKS   = 1 << GAP_LOG2;
    localparam int NUM_TESTS  = 5;
    localparam int T_RESET    = 0;
    localparam int T_TEMPO    = 1;
    localparam int T_PITCH    = 2;
    localparam int T_REST_GAP = 3;
    localparam int T_PAUSE    = 4;

    string test_name [NUM_TESTS] = '{"reset", "tempo", "pitch", "rest_gap", "pause"};
    int    test_checks [NUM_TESTS];
    int    test_errors [NUM_TESTS];
    int    checks;
    int    errors;
    int    steps_int;
    int    cycle;

    ////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////

    int                                 m_tempo;      // Counted clocks in the step
    logic [theme_pkg::STEP_W-1:0]       m_step;
    int                                 prev_tempo;
    logic [theme_pkg::STEP_W-1:0]       prev_step;
    logic                               prev_run;
    logic                               prev2_run;    // Gates the toggle seen now
    logic [theme_pkg::NUM_VOICES-1:0]   prev_speaker;
    logic                               reset_seen;
    logic                               after_reset;
    logic                               seg_valid [theme_pkg::NUM_VOICES];
    logic [theme_pkg::STEP_W-1:0]       seg_step [theme_pkg::NUM_VOICES];
    int                                 seg_toggles [theme_pkg::NUM_VOICES];
    int                                 last_toggle [theme_pkg::NUM_VOICES];
    int                                 pitch_checks [theme_pkg::NUM_VOICES];
    int                                 code;
    logic                               toggled;
    int                                 failed;
    logic                               bad;

    // Clocks between toggles for one note code
    function automatic int expected_interval(input int note_code);
        int octave;
        int semitone;
        int note_len;
        int octave_len;
        octave     = note_code / 12;
        semitone   = note_code % 12;
        note_len   = (int'(theme_pkg::semitone_divider(4'(semitone))) >> PITCH_SHIFT) + 1;
        octave_len = (OCTAVE_TOP >> octave) + 1;
        return note_len * octave_len;
    endfunction

    task automatic record(input int test, input logic ok);
        test_checks[test]++;
        checks++;
        if (!ok) begin
            test_errors[test]++;
            errors++;
        end
    endtask

    task automatic check_value(input int test, input int expected, input int actual,
                               input string what);
        record(test, expected == actual);
        if (expected != actual)
            $display("[FAIL] %s: %s expected %0d, actual %0d",
                     test_name[test], what, expected, actual);
    endtask

    // Skips the first two intervals of every sounding stretch
    task automatic track_interval(input int v, input int note_code);
        if (!seg_valid[v] || seg_step[v] != prev_step) begin
            seg_valid[v]   = 1'b1;
            seg_step[v]    = prev_step;
            seg_toggles[v] = 1;
        end else begin
            seg_toggles[v]++;
            if (seg_toggles[v] >= 4) begin
                pitch_checks[v]++;
                check_value(T_PITCH, expected_interval(note_code), cycle - last_toggle[v],
                            $sformatf("voice %0d step %0d interval", v, prev_step));
            end
        end
        last_toggle[v] = cycle;
    endtask

    ////////////////////////////////////////
    // Per-clock comparison
    ////////////////////////////////////////

    always @(posedge clk) begin
        cycle++;
        if (reset) begin
            if (reset_seen) begin
                check_value(T_RESET, 0, int'(step), "step during reset");
                check_value(T_RESET, 0, int'(speaker), "speaker during reset");
            end
            reset_seen   = 1'b1;
            after_reset  = 1'b1;
            m_tempo      = 0;
            m_step       = '0;
            prev_tempo   = 0;
            prev_step    = '0;
            prev_run     = 1'b0;
            prev2_run    = 1'b0;
            prev_speaker = '0;
            for (int v = 0; v < theme_pkg::NUM_VOICES; v++)
                seg_valid[v] = 1'b0;
            report_done <= 1'b0;
        end else begin
            if (after_reset) begin
                check_value(T_RESET, 0, int'(step), "step after reset");
                check_value(T_RESET, 0, int'(speaker), "speaker after reset");
                after_reset = 1'b0;
            end
            check_value(prev_run ? T_TEMPO : T_PAUSE, int'(m_step), int'(step), "step");

            for (int v = 0; v < theme_pkg::NUM_VOICES; v++) begin
                code    = int'(THEME_SCORE[v][prev_step]);
                toggled = (speaker[v] != prev_speaker[v]);
                if (!prev2_run) begin
                    seg_valid[v] = 1'b0;            // Restart the interval count
                    record(T_PAUSE, !toggled);
                    if (toggled)
                        $display("[FAIL] pause: voice %0d toggled while run was low", v);
                end else if (code == 0 || prev_tempo < GAP_CLKS) begin
                    record(T_REST_GAP, !toggled);
                    if (toggled)
                        $display("[FAIL] rest_gap: voice %0d toggled in step %0d at clock %0d",
                                 v, prev_step, prev_tempo);
                end else if (toggled) begin
                    track_interval(v, code);
                end
            end

            prev2_run    = prev_run;
            prev_run     = run;
            prev_tempo   = m_tempo;
            prev_step    = m_step;
            prev_speaker = speaker;
            if (run) begin
                if (m_tempo == STEP_CLKS - 1) begin
                    m_tempo = 0;
                    m_step  = theme_pkg::STEP_W'((int'(m_step) + 1) % THEME_STEPS);
                    steps_int++;
                end else begin
                    m_tempo++;
                end
            end

            if (report_req && !report_done) begin
                failed = 0;
                for (int t = 0; t < NUM_TESTS; t++) begin
                    bad = (test_errors[t] != 0) || (test_checks[t] == 0);
                    if (t == T_PITCH) begin
                        for (int v = 0; v < theme_pkg::NUM_VOICES; v++)
                            bad = bad || (pitch_checks[v] == 0);   // Both voices measured
                    end
                    if (bad) begin
                        failed++;
                        $display("test %s: failed, %0d of %0d checks wrong",
                                 test_name[t], test_errors[t], test_checks[t]);
                    end else begin
                        $display("test %s: ok, %0d checks", test_name[t], test_checks[t]);
                    end
                end
                tests_failed <= failed;
                report_done  <= 1'b1;
            end
        end
        steps_advanced <= steps_int;
        check_count    <= checks;
        error_count    <= errors;
    end

endmodule

// ==== sim/theme_assertions.sv ====
module theme_assertions (
    input logic                                              clk,
    input logic                                              reset,
    input logic [theme_pkg::STEP_W-1:0]                      step,
    input logic [theme_pkg::NUM_VOICES-1:0]                  speaker,
    input theme_pkg::voice_cmd_t [theme_pkg::NUM_VOICES-1:0] cmd
);

    int fail_count = 0;                 // Read by the testbench at the end

    // A silent command freezes the speaker on the next clock
    for (genvar v = 0; v < theme_pkg::NUM_VOICES; v++) begin : g_voice
        a_silent_hold : assert property (@(posedge clk) disable iff (reset)
            !cmd[v].sounding |=> $stable(speaker[v]))
        else begin
            fail_count++;
            $error("voice %0d speaker changed while its command was silent", v);
        end
    end

    a_step_by_one : assert property (@(posedge clk) disable iff (reset)
        step != $past(step) |-> step == theme_pkg::STEP_W'($past(step) + 1'b1))
    else begin
        fail_count++;
        $error("step moved by more than one");
    end

    a_reset_zero : assert property (@(posedge clk)
        reset && $past(reset) |-> (step == '0 && speaker == '0))
    else begin
        fail_count++;
        $error("step or speaker not zero during reset");
    end

endmodule

bind theme_player theme_assertions u_theme_assertions (
    .clk     (clk),
    .reset   (reset),
    .step    (step),
    .speaker (speaker),
    .cmd     (cmd)
);

// ==== sim/tb_theme_player.sv ====
module tb_theme_player;

    localparam int          STEP_LOG2   = 10;
    localparam int          GAP_LOG2    = 6;
    localparam int          PITCH_SHIFT = 4;
    localparam int          OCTAVE_TOP  = 7;
    localparam int          STEP_CLKS   = 1 << STEP_LOG2;
    localparam int          RUN_STEPS   = 80;       // Steps counted with run high
    localparam int          MAX_CYCLES  = 150000;
    localparam int          DRAIN_CLKS  = 300;      // Final pause before the report
    localparam int          REPORT_WAIT = 100;
    localparam logic [31:0] SEED        = 32'h5f33_853f;

    logic                             clk;
    logic                             reset;
    logic                             run;
    logic [theme_pkg::STEP_W-1:0]     step;
    logic [theme_pkg::NUM_VOICES-1:0] speaker;
    logic                             report_req;
    bit                               report_done;
    int                               steps_advanced;
    int                               check_count;
    int                               error_count;
    int                               tests_failed;
    int                               cycles;
    logic                             timed_out;

    ////////////////////////////////////////
    // DUT and checker
    ////////////////////////////////////////

    theme_player #(
        .STEP_LOG2   (STEP_LOG2),
        .GAP_LOG2    (GAP_LOG2),
        .PITCH_SHIFT (PITCH_SHIFT),
        .OCTAVE_TOP  (OCTAVE_TOP)
    ) u_theme_player (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .step    (step),
        .speaker (speaker)
    );

    theme_checker #(
        .STEP_LOG2   (STEP_LOG2),
        .GAP_LOG2    (GAP_LOG2),
        .PITCH_SHIFT (PITCH_SHIFT),
        .OCTAVE_TOP  (OCTAVE_TOP)
    ) u_theme_checker (
        .clk            (clk),
        .reset          (reset),
        .run            (run),
        .step           (step),
        .speaker        (speaker),
        .report_req     (report_req),
        .report_done    (report_done),
        .steps_advanced (steps_advanced),
        .check_count    (check_count),
        .error_count    (error_count),
        .tests_failed   (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Holds run at one level, stops early once enough steps were counted
    task automatic hold_run(input logic level, input int clocks);
        int n;
        n = 0;
        while (n < clocks && steps_advanced < RUN_STEPS && !timed_out) begin
            @(posedge clk);
            run <= level;
            n++;
            cycles++;
            if (cycles >= MAX_CYCLES)
                timed_out = 1'b1;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus and closing report
    ////////////////////////////////////////

    initial begin
        int high_clks;
        int low_clks;
        int wait_clks;
        reset      = 1'b1;
        run        = 1'b0;
        report_req = 1'b0;
        cycles     = 0;
        timed_out  = 1'b0;
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        while (steps_advanced < RUN_STEPS && !timed_out) begin
            high_clks = int'($urandom_range(6, 1)) * STEP_CLKS
                        + int'($urandom_range(255, 0)) - 128;   // Ends mid-step
            low_clks  = int'($urandom_range(200, 1));
            hold_run(1'b1, high_clks);
            hold_run(1'b0, low_clks);
        end

        if (timed_out) begin
            $display("Timeout: only %0d of %0d steps advanced in %0d clocks",
                     steps_advanced, RUN_STEPS, cycles);
            $display("** FAIL **");
        end else begin
            repeat (DRAIN_CLKS) begin
                @(posedge clk);
                run <= 1'b0;
            end
            report_req <= 1'b1;
            wait_clks = 0;
            while (!report_done && wait_clks < REPORT_WAIT) begin
                @(posedge clk);
                wait_clks++;
            end
            if (!report_done) begin
                $display("Timeout: the checker never finished its report");
                $display("** FAIL **");
            end else begin
                $display("tests failed %0d, checks %0d, errors %0d, assertion failures %0d",
                         tests_failed, check_count, error_count,
                         u_theme_player.u_theme_assertions.fail_count);
                if (tests_failed == 0 && error_count == 0
                    && u_theme_player.u_theme_assertions.fail_count == 0) begin
                    $display("** PASS **");
                end else begin
                    $display("** FAIL **");
                end
            end
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
design/theme_pkg.sv
design/score_sequencer.sv
design/tone_voice.sv
design/theme_player.sv
sim/theme_checker.sv
sim/theme_assertions.sv
sim/tb_theme_player.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_theme_player \
    -f all.f \
    -o tb_theme_player &&
./obj_dir/tb_theme_player | tee /dev/stderr | grep -q '^\*\* PASS \*\*$' &&
echo "theme_player simulation passed" ||
{ echo "theme_player simulation failed"; exit 1; }
